// ==== design/qdr_cmd_issue.sv ====
module qdr_cmd_issue import qdr_pkg::*; (
	input  logic                 clk_ctl,
	input  logic                 arst_n,

	// Host request side
	input  logic                 rd_en,
	input  addr_t                rd_addr,
	input  logic                 wr_en,
	input  addr_t                wr_addr,
	input  ctrl_word_t           wr_data,
	output logic                 ready,

	// Toward the memory
	output logic                 qdr_rps_n,
	output logic                 qdr_wps_n,
	output addr_t                qdr_ra,
	output addr_t                qdr_wa,
	output logic [NUM_LANES-1:0] qdr_bws_n,
	output ctrl_word_t           qdr_d
);

	//////////////////////////////////////////////////////////////////////
	// Startup hold-off

	logic [INIT_CNT_BITS-1:0] init_cnt;
	logic                     rd_go;
	logic                     wr_go;
	ctrl_word_t               wr_data_q;

	// Counter freezes once ready is up
	always_ff @(posedge clk_ctl or negedge arst_n) begin
		if (!arst_n) begin
			init_cnt <= '0;
			ready    <= 1'b0;
		end else if (!ready) begin
			init_cnt <= init_cnt + 1'b1;
			if (init_cnt == INIT_CNT_BITS'(INIT_CYCLES - 1))
				ready <= 1'b1;
		end
	end

	// Requests before startup completes are dropped
	assign rd_go = rd_en & ready;
	assign wr_go = wr_en & ready;

	//////////////////////////////////////////////////////////////////////
	// Port selects and byte selects

	always_ff @(posedge clk_ctl or negedge arst_n) begin
		if (!arst_n) begin
			qdr_rps_n <= 1'b1;
			qdr_wps_n <= 1'b1;
			qdr_bws_n <= '1;
		end else begin
			qdr_rps_n <= ~rd_go;
			qdr_wps_n <= ~wr_go;
			// All lanes written, one cycle behind the write select
			qdr_bws_n <= {NUM_LANES{qdr_wps_n}};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Addresses and write data

	always_ff @(posedge clk_ctl) begin
		if (rd_go)
			qdr_ra <= rd_addr;
		if (wr_go) begin
			qdr_wa    <= wr_addr;
			wr_data_q <= wr_data;
		end
		// Second stage, lines up with qdr_bws_n
		qdr_d <= wr_data_q;
	end

	// A select only follows a request taken while ready was high
	sel_after_ready: assert property (@(posedge clk_ctl) disable iff (!arst_n)
		(!qdr_rps_n || !qdr_wps_n) |-> $past(ready));

endmodule

// ==== design/qdr_ctl_top.sv ====
module qdr_ctl_top import qdr_pkg::*; (
	input  logic                 clk_ctl,
	input  logic                 arst_n,

	// Host side
	input  logic                 rd_en,
	input  addr_t                rd_addr,
	input  logic                 wr_en,
	input  addr_t                wr_addr,
	input  ctrl_word_t           wr_data,
	output logic                 ready,
	output logic                 rd_valid,
	output ctrl_word_t           rd_data,

	// Memory side
	output logic                 qdr_rps_n,
	output logic                 qdr_wps_n,
	output addr_t                qdr_ra,
	output addr_t                qdr_wa,
	output logic [NUM_LANES-1:0] qdr_bws_n,
	output ctrl_word_t           qdr_d,
	input  ctrl_word_t           qdr_q,
	input  logic                 qdr_qvld
);

	logic                 lane_push;
	lane_word_t           lane_din  [NUM_LANES];
	logic [NUM_LANES-1:0] lane_empty;
	lane_word_t           lane_dout [NUM_LANES];
	logic                 lane_pop;

	//////////////////////////////////////////////////////////////////////
	// Command path

	qdr_cmd_issue u_cmd_issue (
		.clk_ctl   (clk_ctl),
		.arst_n    (arst_n),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.ready     (ready),
		.qdr_rps_n (qdr_rps_n),
		.qdr_wps_n (qdr_wps_n),
		.qdr_ra    (qdr_ra),
		.qdr_wa    (qdr_wa),
		.qdr_bws_n (qdr_bws_n),
		.qdr_d     (qdr_d)
	);

	//////////////////////////////////////////////////////////////////////
	// Read path

	qdr_read_capture u_read_capture (
		.clk_ctl   (clk_ctl),
		.arst_n    (arst_n),
		.qdr_q     (qdr_q),
		.qdr_qvld  (qdr_qvld),
		.lane_push (lane_push),
		.lane_din  (lane_din)
	);

	// One FIFO per byte lane, all pushed and popped together
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		qdr_lane_fifo u_lane_fifo (
			.clk_ctl (clk_ctl),
			.arst_n  (arst_n),
			.push    (lane_push),
			.din     (lane_din[i]),
			.pop     (lane_pop),
			.dout    (lane_dout[i]),
			.empty   (lane_empty[i]),
			.full    ()
		);
	end

	qdr_read_return u_read_return (
		.clk_ctl    (clk_ctl),
		.arst_n     (arst_n),
		.lane_empty (lane_empty),
		.lane_dout  (lane_dout),
		.lane_pop   (lane_pop),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

endmodule

// ==== design/qdr_lane_fifo.sv ====
module qdr_lane_fifo import qdr_pkg::*; (
	input  logic       clk_ctl,
	input  logic       arst_n,

	// Write side
	input  logic       push,
	input  lane_word_t din,

	// Read side, head word shows on dout while not empty
	input  logic       pop,
	output lane_word_t dout,
	output logic       empty,
	output logic       full
);

	//////////////////////////////////////////////////////////////////////
	// Storage and pointers

	lane_word_t               mem [FIFO_DEPTH];
	logic [FIFO_PTR_BITS-1:0] wr_ptr;
	logic [FIFO_PTR_BITS-1:0] rd_ptr;
	logic [FIFO_CNT_BITS-1:0] count;

	// Depth is a power of two so pointers wrap on their own
	always_ff @(posedge clk_ctl or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_ctl) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	// First word fall through
	assign dout  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == FIFO_CNT_BITS'(FIFO_DEPTH));

	// Drain rate matches arrival rate, so these never fire in operation
	no_overflow: assert property (@(posedge clk_ctl) disable iff (!arst_n)
		full |-> !push || pop);
	no_underflow: assert property (@(posedge clk_ctl) disable iff (!arst_n)
		pop |-> !empty);

endmodule

// ==== design/qdr_pkg.sv ====
package qdr_pkg;

	//////////////////////////////////////////////////////////////////////
	// Memory geometry

	// One beat on the QDR data bus
	localparam int RAM_WIDTH      = 36;
	// Burst length four, all beats carried in one controller cycle
	localparam int BEATS          = 4;
	localparam int CTRL_WIDTH     = BEATS * RAM_WIDTH;
	localparam int ADDR_BITS      = 18;

	// Byte lanes of nine bits, one write select per lane
	localparam int LANE_BITS      = 9;
	localparam int NUM_LANES      = RAM_WIDTH / LANE_BITS;
	localparam int LANE_WORD_BITS = BEATS * LANE_BITS;

	//////////////////////////////////////////////////////////////////////
	// Buffering and startup

	localparam int FIFO_DEPTH     = 8;
	localparam int FIFO_PTR_BITS  = $clog2(FIFO_DEPTH);
	// Count has to reach FIFO_DEPTH itself
	localparam int FIFO_CNT_BITS  = $clog2(FIFO_DEPTH + 1);

	// Hold-off after reset, stands in for SERDES and FIFO reset time
	localparam int INIT_CYCLES    = 32;
	localparam int INIT_CNT_BITS  = $clog2(INIT_CYCLES);

	// Request address
	typedef logic [ADDR_BITS-1:0] addr_t;
	// Beat b at bits b*36 upward, lane i of a beat at i*9 upward
	typedef logic [CTRL_WIDTH-1:0] ctrl_word_t;
	// Four 9-bit pieces of one lane, beat 0 in the low bits
	typedef logic [LANE_WORD_BITS-1:0] lane_word_t;

endpackage

// ==== design/qdr_read_capture.sv ====
module qdr_read_capture import qdr_pkg::*; (
	input  logic       clk_ctl,
	input  logic       arst_n,

	// Returning burst from the memory
	input  ctrl_word_t qdr_q,
	input  logic       qdr_qvld,

	// Lane-major words toward the lane FIFOs
	output logic       lane_push,
	output lane_word_t lane_din [NUM_LANES]
);

	//////////////////////////////////////////////////////////////////////
	// Beat-major to lane-major regroup

	lane_word_t q_lanes [NUM_LANES];

	// Lane i collects its nine bits out of every beat
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			for (int b = 0; b < BEATS; b++) begin
				q_lanes[i][b*LANE_BITS +: LANE_BITS] =
					qdr_q[b*RAM_WIDTH + i*LANE_BITS +: LANE_BITS];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Capture registers

	// Valid strobe, one cycle behind qdr_qvld
	always_ff @(posedge clk_ctl or negedge arst_n) begin
		if (!arst_n)
			lane_push <= 1'b0;
		else
			lane_push <= qdr_qvld;
	end

	// Data is only looked at when lane_push is high
	always_ff @(posedge clk_ctl) begin
		for (int i = 0; i < NUM_LANES; i++) begin
			if (qdr_qvld)
				lane_din[i] <= q_lanes[i];
		end
	end

endmodule

// ==== design/qdr_read_return.sv ====
module qdr_read_return import qdr_pkg::*; (
	input  logic                 clk_ctl,
	input  logic                 arst_n,

	// From the lane FIFOs
	input  logic [NUM_LANES-1:0] lane_empty,
	input  lane_word_t           lane_dout [NUM_LANES],
	output logic                 lane_pop,

	// Host read return
	output logic                 rd_valid,
	output ctrl_word_t           rd_data
);

	//////////////////////////////////////////////////////////////////////
	// Pop and reassemble

	ctrl_word_t rd_word;

	// Lanes move in lockstep, lane 0 speaks for all of them
	assign lane_pop = ~lane_empty[0];

	// Lane-major back to beat-major
	always_comb begin
		for (int b = 0; b < BEATS; b++) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				rd_word[b*RAM_WIDTH + i*LANE_BITS +: LANE_BITS] =
					lane_dout[i][b*LANE_BITS +: LANE_BITS];
			end
		end
	end

	always_ff @(posedge clk_ctl or negedge arst_n) begin
		if (!arst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= lane_pop;
	end

	always_ff @(posedge clk_ctl) begin
		if (lane_pop)
			rd_data <= rd_word;
	end

	// Every lane gets the same push and pop, so the flags never split
	lanes_in_step: assert property (@(posedge clk_ctl) disable iff (!arst_n)
		(&lane_empty) == (|lane_empty));

endmodule

// ==== qdr_ctl.f ====
design/qdr_pkg.sv
design/qdr_cmd_issue.sv
design/qdr_read_capture.sv
design/qdr_lane_fifo.sv
design/qdr_read_return.sv
design/qdr_ctl_top.sv
testbench/qdr_ctl_checker.sv
testbench/qdr_ctl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the QDR controller testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert --top-module qdr_ctl_tb -f qdr_ctl.f -o qdr_ctl_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/qdr_ctl_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
exit 0

// ==== testbench/qdr_ctl_checker.sv ====
module qdr_ctl_checker import qdr_pkg::*; (
	input  logic                 clk_ctl,
	input  logic                 arst_n,
	input  logic                 rd_en,
	input  addr_t                rd_addr,
	input  logic                 wr_en,
	input  addr_t                wr_addr,
	input  ctrl_word_t           wr_data,
	input  logic                 ready,
	input  logic                 rd_valid,
	input  ctrl_word_t           rd_data,
	input  logic                 qdr_rps_n,
	input  logic                 qdr_wps_n,
	input  addr_t                qdr_ra,
	input  addr_t                qdr_wa,
	input  logic [NUM_LANES-1:0] qdr_bws_n,
	input  ctrl_word_t           qdr_d,
	output int                   err_count,
	output int                   reads_issued,
	output int                   reads_returned
);

	// Memory image, and expected read words in request order
	ctrl_word_t img [addr_t];
	ctrl_word_t expect_q [$];
	int         errs = 0;
	int         n_rd = 0;
	int         n_ret = 0;
	int         edges = 0;
	// Host inputs as seen at the last rising edge
	logic       arst_s = 1'b0;
	logic       rd_en_s = 1'b0;
	addr_t      rd_addr_s = '0;
	logic       wr_en_s = 1'b0;
	addr_t      wr_addr_s = '0;
	ctrl_word_t wr_data_s = '0;
	// Expected ready going into the next edge
	logic       ready_s = 1'b0;
	logic       wr_prev = 1'b0;
	ctrl_word_t wd_prev = '0;
	logic       rd_acc;
	logic       wr_acc;

	assign err_count      = errs;
	assign reads_issued   = n_rd;
	assign reads_returned = n_ret;

	task automatic check_value(input string name, input ctrl_word_t got, input ctrl_word_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
			errs++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sampling at the rising edge

	always @(posedge clk_ctl) begin
		arst_s    <= arst_n;
		rd_en_s   <= rd_en;
		rd_addr_s <= rd_addr;
		wr_en_s   <= wr_en;
		wr_addr_s <= wr_addr;
		wr_data_s <= wr_data;
		// Ready is due once INIT_CYCLES edges have passed since reset release
		if (!arst_n)
			edges <= 0;
		else if (edges < INIT_CYCLES)
			edges <= edges + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Comparing mid-cycle where DUT outputs are settled

	always @(negedge clk_ctl) begin
		// Request taken only if ready was high going into that edge
		rd_acc = arst_s && rd_en_s && ready_s;
		wr_acc = arst_s && wr_en_s && ready_s;
		if (wr_acc)
			img[wr_addr_s] = wr_data_s;
		if (rd_acc) begin
			// Untouched addresses read back as zero
			expect_q.push_back(img.exists(rd_addr_s) ? img[rd_addr_s] : '0);
			n_rd++;
		end
		check_value("ready", ctrl_word_t'(ready), ctrl_word_t'(edges >= INIT_CYCLES));
		// Selects pulse for one cycle right after an accepted request
		check_value("qdr_rps_n", ctrl_word_t'(qdr_rps_n), ctrl_word_t'(!rd_acc));
		check_value("qdr_wps_n", ctrl_word_t'(qdr_wps_n), ctrl_word_t'(!wr_acc));
		// Addresses go out together with their select
		if (rd_acc)
			check_value("qdr_ra", ctrl_word_t'(qdr_ra), ctrl_word_t'(rd_addr_s));
		if (wr_acc)
			check_value("qdr_wa", ctrl_word_t'(qdr_wa), ctrl_word_t'(wr_addr_s));
		// Byte selects all low one cycle behind the write select
		check_value("qdr_bws_n", ctrl_word_t'(qdr_bws_n),
			ctrl_word_t'({NUM_LANES{!wr_prev}}));
		// Write data lines up with the byte selects
		if (wr_prev)
			check_value("qdr_d", qdr_d, wd_prev);
		if (rd_valid) begin
			if (expect_q.size() == 0) begin
				$display("rd_valid pulsed with no read outstanding");
				errs++;
			end else begin
				check_value("rd_data", rd_data, expect_q.pop_front());
			end
			n_ret++;
		end
		wr_prev = wr_acc;
		wd_prev = wr_data_s;
		ready_s = (edges >= INIT_CYCLES);
	end

endmodule

// ==== testbench/qdr_ctl_tb.sv ====
module qdr_ctl_tb import qdr_pkg::*; ();

	// One request row: rd, rd_addr, wr, wr_addr, data select
	typedef struct packed {
		logic       rd;
		addr_t      ra;
		logic       wr;
		addr_t      wa;
		logic [1:0] dsel;
	} row_t;

	logic clk_ctl = 1'b0;
	logic arst_n, rd_en, wr_en, ready, rd_valid, qdr_rps_n, qdr_wps_n;
	addr_t rd_addr, wr_addr, qdr_ra, qdr_wa;
	ctrl_word_t wr_data, rd_data, qdr_d;
	logic [NUM_LANES-1:0] qdr_bws_n;
	ctrl_word_t qdr_q = '0;
	logic qdr_qvld = 1'b0;
	int err_count, reads_issued, reads_returned;
	int tb_errs = 0;
	logic [31:0] lfsr_state = 32'h7950;

	// Data select 0 is random, 1 all ones, 2 a marker per beat and lane
	row_t stim [17] = '{
		'{1'b0, 18'h00000, 1'b1, 18'h00010, 2'd2},
		'{1'b1, 18'h00010, 1'b0, 18'h00000, 2'd0},
		'{1'b1, 18'h3ffff, 1'b0, 18'h00000, 2'd0},
		'{1'b0, 18'h00000, 1'b1, 18'h00020, 2'd0},
		'{1'b0, 18'h00000, 1'b1, 18'h00021, 2'd0},
		'{1'b0, 18'h00000, 1'b1, 18'h00022, 2'd1},
		// Back-to-back reads, several in flight
		'{1'b1, 18'h00020, 1'b0, 18'h00000, 2'd0},
		'{1'b1, 18'h00021, 1'b0, 18'h00000, 2'd0},
		'{1'b1, 18'h00022, 1'b0, 18'h00000, 2'd0},
		'{1'b1, 18'h00010, 1'b0, 18'h00000, 2'd0},
		// Read and write in the same cycle, different addresses
		'{1'b1, 18'h00030, 1'b1, 18'h00040, 2'd0},
		'{1'b1, 18'h00040, 1'b1, 18'h00041, 2'd2},
		'{1'b1, 18'h00041, 1'b0, 18'h00000, 2'd0},
		'{1'b0, 18'h00000, 1'b0, 18'h00000, 2'd0},
		'{1'b1, 18'h12345, 1'b1, 18'h00020, 2'd1},
		'{1'b1, 18'h00020, 1'b1, 18'h2aaaa, 2'd0},
		'{1'b1, 18'h2aaaa, 1'b0, 18'h00000, 2'd0}
	};

	always #2 clk_ctl = ~clk_ctl;

	qdr_ctl_top DUT (.*);

	qdr_ctl_checker u_checker (.*);

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output ctrl_word_t w);
		w = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w[k] = lfsr_state[0];
		end
	endtask

	// Every 9-bit piece names its own beat and lane
	function automatic ctrl_word_t marker_word();
		ctrl_word_t w;
		for (int b = 0; b < BEATS; b++)
			for (int i = 0; i < NUM_LANES; i++)
				w[b*RAM_WIDTH + i*LANE_BITS +: LANE_BITS] = LANE_BITS'(b * 16 + i + 1);
		return w;
	endfunction

	task automatic pick_data(input logic [1:0] sel, output ctrl_word_t w);
		case (sel)
			2'd0:    take_bits(CTRL_WIDTH, w);
			2'd1:    w = '1;
			default: w = marker_word();
		endcase
	endtask

	task automatic apply_request(input logic r, input addr_t ra, input logic w, input addr_t wa,
		input ctrl_word_t d);
		rd_en   = r;
		rd_addr = ra;
		wr_en   = w;
		wr_addr = wa;
		wr_data = d;
	endtask

	//////////////////////////////////////////////////////////////////////
	// QDR SRAM model, starts all zero

	ctrl_word_t mem [addr_t];
	logic       wr_pend = 1'b0;
	addr_t      wa_pend = '0;
	logic [2:0] qv_pipe = '0;
	ctrl_word_t q_pipe [3] = '{default: '0};

	function automatic ctrl_word_t mem_read(input addr_t a);
		return mem.exists(a) ? mem[a] : '0;
	endfunction

	always @(negedge clk_ctl) begin
		ctrl_word_t w;
		// Write data arrives one cycle after its select, masked per lane
		if (wr_pend) begin
			w = mem_read(wa_pend);
			for (int b = 0; b < BEATS; b++)
				for (int i = 0; i < NUM_LANES; i++)
					if (!qdr_bws_n[i])
						w[b*RAM_WIDTH + i*LANE_BITS +: LANE_BITS] =
							qdr_d[b*RAM_WIDTH + i*LANE_BITS +: LANE_BITS];
			mem[wa_pend] = w;
		end
		wr_pend = !qdr_wps_n;
		wa_pend = qdr_wa;
		// Read latency of three cycles from the read select
		qdr_qvld <= qv_pipe[2];
		qdr_q    <= q_pipe[2];
		qv_pipe   = {qv_pipe[1:0], !qdr_rps_n};
		q_pipe[2] = q_pipe[1];
		q_pipe[1] = q_pipe[0];
		q_pipe[0] = qdr_rps_n ? '0 : mem_read(qdr_ra);
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int         wait_cnt;
		ctrl_word_t w;
		arst_n = 1'b0;
		apply_request(1'b0, '0, 1'b0, '0, '0);
		repeat (16) @(posedge clk_ctl);
		@(negedge clk_ctl);
		arst_n = 1'b1;
		// Requests during startup must be dropped
		for (int k = 0; k < 4; k++) begin
			@(negedge clk_ctl);
			take_bits(CTRL_WIDTH, w);
			apply_request(1'b1, addr_t'(w), 1'b1, addr_t'(w >> 40), w);
		end
		@(negedge clk_ctl);
		apply_request(1'b0, '0, 1'b0, '0, '0);
		wait_cnt = 0;
		while (!ready && wait_cnt < 100) begin
			@(negedge clk_ctl);
			wait_cnt++;
		end
		if (!ready) begin
			$display("Timeout waiting for ready to rise after reset");
			tb_errs++;
		end
		for (int k = 0; k < $size(stim); k++) begin
			@(negedge clk_ctl);
			pick_data(stim[k].dsel, w);
			apply_request(stim[k].rd, stim[k].ra, stim[k].wr, stim[k].wa, w);
		end
		@(negedge clk_ctl);
		apply_request(1'b0, '0, 1'b0, '0, '0);
		// Drain, then a short window to catch any extra rd_valid
		wait_cnt = 0;
		while (reads_returned != reads_issued && wait_cnt < 200) begin
			@(posedge clk_ctl);
			wait_cnt++;
		end
		repeat (8) @(posedge clk_ctl);
		if (reads_returned != reads_issued) begin
			$display("ERROR reads_returned: got 0x%0h expected 0x%0h",
				reads_returned, reads_issued);
			tb_errs++;
		end
		$display("Errors %0d (checker %0d, testbench %0d), reads issued %0d, returned %0d",
			err_count + tb_errs, err_count, tb_errs, reads_issued, reads_returned);
		if (err_count + tb_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
